/* hw/kbd_params.svh */
`ifndef KBD_PARAMS_SVH
`define KBD_PARAMS_SVH

// number of entries in the keyboard FIFO, must stay a power of two
`define KBD_FIFO_DEPTH 8

// FIFO pointer width: log2 of the depth plus one wrap bit
`define KBD_PTR_W 4

// width of one PS/2 scan code byte
`define KBD_CODE_W 8

`endif

/* hw/kbd_pkg.sv */
`include "kbd_params.svh"

package kbd_pkg;

  // one PS/2 frame as it appears on the wire, lsb is the first bit received
  // start is always 0 and stop is always 1 on a clean frame
  typedef struct packed {
    logic                   stop;
    logic                   odd_parity;
    logic [`KBD_CODE_W-1:0] data;
    logic                   start;
  } t_ps2_frame;

  // one queued key event as seen by software
  // error set means code holds the byte of a damaged frame
  typedef struct packed {
    logic                   error;
    logic                   extended;
    logic [`KBD_CODE_W-1:0] code;
  } t_kbd_entry;

  // prefix tracker states
  // E0 opens an extended code, F0 opens a break code
  typedef enum logic [1:0] {
    PFX_IDLE,
    PFX_EXT,
    PFX_BREAK,
    PFX_EXT_BREAK
  } t_prefix_state;

endpackage

/* hw/ps2_frame_if.sv */
`timescale 1ns/100ps

// kbd_clk domain bundle from the frame shifter to its consumers
interface ps2_frame_if import kbd_pkg::*; ();

  // high in the cycle whose rising edge shifts in the stop bit
  logic       frame_strobe;
  // registered ten bits plus the bit on data_in right now
  t_ps2_frame frame;
  // core reset after the kbd_clk metaflop
  logic       rst_kc;

  modport source (
    output frame_strobe,
    output frame,
    output rst_kc
  );

  modport check (
    input frame_strobe,
    input frame
  );

  modport tracker (
    input frame_strobe,
    input frame,
    input rst_kc
  );

endinterface

/* hw/ps2_frame_shifter.sv */
`timescale 1ns/100ps
`include "kbd_params.svh"

module ps2_frame_shifter (
  input  logic        kbd_clk,
  input  logic        data_in,
  input  logic        reset,
  ps2_frame_if.source frame_port
);

  // start + data + parity + stop
  localparam int         FRAME_W  = `KBD_CODE_W + 3;
  localparam logic [3:0] LAST_CNT = 4'(FRAME_W - 1);

  logic               rst_meta;
  logic               rst_kc;
  logic [FRAME_W-2:0] shift_q;
  logic [3:0]         count_q;

  // core reset carried into kbd_clk through two flops
  // rst_kc lingers for two kbd_clk edges after reset falls
  always_ff @(posedge kbd_clk) begin
    rst_meta <= reset;
    rst_kc   <= rst_meta;
  end

  // bits arrive lsb first, so shift in at the top
  // after ten bits the start bit sits in shift_q[0]
  always_ff @(posedge kbd_clk) begin
    shift_q <= {data_in, shift_q[FRAME_W-2:1]};
  end

  // counts bits already held, wraps as the stop bit comes in
  always_ff @(posedge kbd_clk) begin
    if (rst_kc) begin
      count_q <= '0;
    end else if (count_q == LAST_CNT) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 4'd1;
    end
  end

  // frame is complete on the edge that takes data_in as the stop bit
  assign frame_port.frame_strobe = (count_q == LAST_CNT);
  assign frame_port.frame        = {data_in, shift_q};
  assign frame_port.rst_kc       = rst_kc;

  // bit counter must never run past the stop bit position
  a_count_range: assert property (
    @(posedge kbd_clk) disable iff (rst_kc)
    count_q <= LAST_CNT
  );

endmodule

/* hw/ps2_frame_checker.sv */
`timescale 1ns/100ps

module ps2_frame_checker (
  ps2_frame_if.check frame_port,
  output logic       frame_ok
);

  logic start_ok;
  logic stop_ok;
  logic parity_ok;

  // start bit is always driven low by the keyboard
  assign start_ok = (frame_port.frame.start == 1'b0);

  // stop bit is always high, a low stop bit means framing was lost
  assign stop_ok = (frame_port.frame.stop == 1'b1);

  // odd parity over data and parity bit together
  // xor reduction gives 1 for an odd count of ones
  assign parity_ok = ^{frame_port.frame.odd_parity, frame_port.frame.data};

  // evaluated on every frame, the writer qualifies it with the strobe
  assign frame_ok = start_ok && stop_ok && parity_ok;

  // the shifter must hand over a fully known frame when it strobes
  always_comb begin
    if (frame_port.frame_strobe) begin
      a_frame_ok_known: assert (!$isunknown(frame_ok));
    end
  end

endmodule

/* hw/scancode_tracker.sv */
`timescale 1ns/100ps
`include "kbd_params.svh"

module scancode_tracker import kbd_pkg::*; (
  input  logic         kbd_clk,
  ps2_frame_if.tracker frame_port,
  input  logic         frame_ok,
  output logic         release_hit,
  output logic         release_ext
);

  // prefix bytes of scan code set 2
  localparam logic [`KBD_CODE_W-1:0] CODE_EXT   = 8'hE0;
  localparam logic [`KBD_CODE_W-1:0] CODE_BREAK = 8'hF0;

  t_prefix_state          state_q;
  t_prefix_state          state_next;
  logic [`KBD_CODE_W-1:0] code;
  logic                   is_prefix;

  assign code      = frame_port.frame.data;
  assign is_prefix = (code == CODE_EXT) || (code == CODE_BREAK);

  always_comb begin
    state_next = state_q;
    if (frame_port.frame_strobe) begin
      if (!frame_ok) begin
        // a damaged frame drops any pending prefix
        state_next = PFX_IDLE;
      end else if (code == CODE_EXT) begin
        state_next = PFX_EXT;
      end else if (code == CODE_BREAK) begin
        state_next = (state_q == PFX_EXT) ? PFX_EXT_BREAK : PFX_BREAK;
      end else begin
        // plain code ends the sequence, make or break
        state_next = PFX_IDLE;
      end
    end
  end

  // state only moves on the strobe edge, see state_next
  always_ff @(posedge kbd_clk) begin
    if (frame_port.rst_kc) begin
      state_q <= PFX_IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  // non prefix byte after F0 completes a release
  assign release_hit = !is_prefix &&
                       ((state_q == PFX_BREAK) || (state_q == PFX_EXT_BREAK));
  assign release_ext = (state_q == PFX_EXT_BREAK);

endmodule

/* hw/kbd_entry_writer.sv */
`timescale 1ns/100ps
`include "kbd_params.svh"

module kbd_entry_writer import kbd_pkg::*; (
  input  logic                   kbd_clk,
  input  logic                   rst_kc,
  input  logic                   scanf_en,
  input  logic                   frame_strobe,
  input  logic [`KBD_CODE_W-1:0] frame_data,
  input  logic                   frame_ok,
  input  logic                   release_hit,
  input  logic                   release_ext,
  output logic                   wr_en,
  output t_kbd_entry             wr_entry
);

  logic scanf_meta;
  logic scanf_en_kc;

  // software capture enable comes from the core domain
  always_ff @(posedge kbd_clk) begin
    if (rst_kc) begin
      scanf_meta  <= 1'b0;
      scanf_en_kc <= 1'b0;
    end else begin
      scanf_meta  <= scanf_en;
      scanf_en_kc <= scanf_meta;
    end
  end

  // queue bad frames and completed releases, make codes and prefixes are skipped
  assign wr_en = frame_strobe && scanf_en_kc && (!frame_ok || release_hit);

  // bad frame keeps the received byte so software can see what came in
  always_comb begin
    wr_entry.error    = !frame_ok;
    wr_entry.extended = frame_ok && release_ext;
    wr_entry.code     = frame_data;
  end

  // writes happen only on the edge that completes a frame
  a_wr_on_strobe: assert property (
    @(posedge kbd_clk) disable iff (rst_kc)
    wr_en |-> frame_strobe
  );

endmodule

/* hw/kbd_gray_fifo.sv */
`timescale 1ns/100ps
`include "kbd_params.svh"

module kbd_gray_fifo import kbd_pkg::*; (
  input  logic       kbd_clk,
  input  logic       rst_kc,
  input  logic       wr_en,
  input  t_kbd_entry wr_entry,
  input  logic       core_clk,
  input  logic       reset,
  input  logic       read_en,
  output logic       data_ready,
  output t_kbd_entry rd_entry
);

  localparam int PTR_W  = `KBD_PTR_W;
  localparam int ADDR_W = PTR_W - 1;

  t_kbd_entry mem [`KBD_FIFO_DEPTH];

  // write side, kbd_clk domain
  logic [PTR_W-1:0] wr_bin_q;
  logic [PTR_W-1:0] wr_bin_next;
  logic [PTR_W-1:0] wr_gray_q;
  logic [PTR_W-1:0] rd_gray_meta_kc;
  logic [PTR_W-1:0] rd_gray_kc;
  logic             full;
  logic             push;

  // read side, core_clk domain
  logic [PTR_W-1:0] rd_bin_q;
  logic [PTR_W-1:0] rd_bin_next;
  logic [PTR_W-1:0] rd_gray_q;
  logic [PTR_W-1:0] wr_gray_meta_cc;
  logic [PTR_W-1:0] wr_gray_cc;
  logic             empty;
  logic             pop;

  // full when the top two gray bits differ and the rest match
  // rd pointer only updates on kbd_clk edges, so full may be stale but never late
  assign full        = (wr_gray_q == {~rd_gray_kc[PTR_W-1 -: 2], rd_gray_kc[PTR_W-3:0]});
  assign push        = wr_en && !full;
  assign wr_bin_next = wr_bin_q + PTR_W'(push);

  always_ff @(posedge kbd_clk) begin
    if (rst_kc) begin
      wr_bin_q        <= '0;
      wr_gray_q       <= '0;
      rd_gray_meta_kc <= '0;
      rd_gray_kc      <= '0;
    end else begin
      wr_bin_q        <= wr_bin_next;
      wr_gray_q       <= wr_bin_next ^ (wr_bin_next >> 1);
      rd_gray_meta_kc <= rd_gray_q;
      rd_gray_kc      <= rd_gray_meta_kc;
    end
  end

  // entry dropped when full, older entries stay intact
  always_ff @(posedge kbd_clk) begin
    if (push) begin
      mem[wr_bin_q[ADDR_W-1:0]] <= wr_entry;
    end
  end

  // empty when both gray pointers match, wrap bit included
  assign empty       = (rd_gray_q == wr_gray_cc);
  assign data_ready  = !empty;
  assign pop         = read_en && data_ready;
  assign rd_bin_next = rd_bin_q + PTR_W'(pop);

  always_ff @(posedge core_clk) begin
    if (reset) begin
      rd_bin_q        <= '0;
      rd_gray_q       <= '0;
      wr_gray_meta_cc <= '0;
      wr_gray_cc      <= '0;
    end else begin
      rd_bin_q        <= rd_bin_next;
      rd_gray_q       <= rd_bin_next ^ (rd_bin_next >> 1);
      wr_gray_meta_cc <= wr_gray_q;
      wr_gray_cc      <= wr_gray_meta_cc;
    end
  end

  // first word fall through, head entry always visible
  assign rd_entry = mem[rd_bin_q[ADDR_W-1:0]];

  // read pointer only moves after a cycle with data present
  a_no_pop_empty: assert property (
    @(posedge core_clk) disable iff (reset)
    (rd_bin_q != $past(rd_bin_q)) |-> $past(data_ready)
  );

endmodule

/* hw/kbd_controller.sv */
`timescale 1ns/100ps
`include "kbd_params.svh"

module kbd_controller import kbd_pkg::*; (
  // PS/2 side
  input  logic                   kbd_clk,
  input  logic                   data_in,
  // core side
  input  logic                   core_clk,
  input  logic                   reset,
  input  logic                   read_en,
  input  logic                   scanf_en,
  output logic [`KBD_CODE_W-1:0] data_out,
  output logic                   extended,
  output logic                   error,
  output logic                   valid,
  output logic                   data_ready
);

  ps2_frame_if frame_bus ();

  logic       frame_ok;
  logic       release_hit;
  logic       release_ext;
  logic       wr_en;
  t_kbd_entry wr_entry;
  t_kbd_entry rd_entry;

  // serial bits to frames, also owns the kbd_clk reset
  ps2_frame_shifter ps2_frame_shifter_i (
    .kbd_clk    (kbd_clk),
    .data_in    (data_in),
    .reset      (reset),
    .frame_port (frame_bus.source)
  );

  ps2_frame_checker ps2_frame_checker_i (
    .frame_port (frame_bus.check),
    .frame_ok   (frame_ok)
  );

  scancode_tracker scancode_tracker_i (
    .kbd_clk     (kbd_clk),
    .frame_port  (frame_bus.tracker),
    .frame_ok    (frame_ok),
    .release_hit (release_hit),
    .release_ext (release_ext)
  );

  kbd_entry_writer kbd_entry_writer_i (
    .kbd_clk      (kbd_clk),
    .rst_kc       (frame_bus.rst_kc),
    .scanf_en     (scanf_en),
    .frame_strobe (frame_bus.frame_strobe),
    .frame_data   (frame_bus.frame.data),
    .frame_ok     (frame_ok),
    .release_hit  (release_hit),
    .release_ext  (release_ext),
    .wr_en        (wr_en),
    .wr_entry     (wr_entry)
  );

  // crossing from kbd_clk to core_clk
  kbd_gray_fifo kbd_gray_fifo_i (
    .kbd_clk    (kbd_clk),
    .rst_kc     (frame_bus.rst_kc),
    .wr_en      (wr_en),
    .wr_entry   (wr_entry),
    .core_clk   (core_clk),
    .reset      (reset),
    .read_en    (read_en),
    .data_ready (data_ready),
    .rd_entry   (rd_entry)
  );

  assign data_out = rd_entry.code;
  assign extended = rd_entry.extended;
  assign error    = rd_entry.error;

  // valid marks the cycle the head entry is taken
  assign valid = data_ready & read_en;

endmodule

/* dv/kbd_controller_tb.sv */
`timescale 1ns/100ps
`include "kbd_params.svh"

module kbd_controller_tb import kbd_pkg::*; ();

  // kbd_clk half period in core cycles
  localparam int          KBD_HALF     = 3;
  localparam int          DRIVE_DLY    = 5;
  localparam int          RESET_CYCLES = 10;
  localparam int          RESET_PULSES = 12;
  localparam logic [31:0] RAND_SEED    = 32'h231c_2767;
  // tests 1 to 4 send 14 frames, test 5 sends depth + 2 releases of two frames each
  localparam int NUM_FRAMES      = 14 + 2 * (`KBD_FIFO_DEPTH + 2);
  localparam int FRAME_CYCLES    = 2 * KBD_HALF * 11 + KBD_HALF;
  // longest wait for the FIFO to empty after one test
  localparam int DRAIN_LIMIT     = 20 * `KBD_FIFO_DEPTH;
  localparam int NUM_DRAINS      = 5;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES +
                                   NUM_DRAINS * (DRAIN_LIMIT + 8) + 600;

  logic       kbd_clk;
  logic       data_in;
  logic       core_clk = 1'b0;
  logic       reset;
  logic       read_en;
  logic       scanf_en;
  logic [7:0] data_out;
  logic       extended;
  logic       error;
  logic       valid;
  logic       data_ready;

  // expected entries in FIFO order, head mirrored into plain variables
  t_kbd_entry exp_q[$];
  t_kbd_entry exp_head   = '0;
  int         exp_count  = 0;
  int         popped     = 0;
  int         errors     = 0;
  logic       reads_off  = 1'b1;
  logic       took_head  = 1'b0;
  logic       capture_on = 1'b1;
  // keyboard-side prefix state as the model sees it
  logic       pfx_ext    = 1'b0;
  logic       pfx_brk    = 1'b0;

  kbd_controller kbd_controller_i (
    .kbd_clk    (kbd_clk),
    .data_in    (data_in),
    .core_clk   (core_clk),
    .reset      (reset),
    .read_en    (read_en),
    .scanf_en   (scanf_en),
    .data_out   (data_out),
    .extended   (extended),
    .error      (error),
    .valid      (valid),
    .data_ready (data_ready)
  );

  always #50 core_clk = ~core_clk;

  // valid is exactly the and of data_ready and read_en
  a_valid_gate: assert property (@(posedge core_clk) disable iff (reset)
    valid == (data_ready && read_en))
    else begin
      errors++;
      $display("MISMATCH at %0t: valid=%b data_ready=%b read_en=%b", $time, valid,
               data_ready, read_en);
    end

  // covers data_ready low after reset and while capture is off
  a_ready_has_entry: assert property (@(posedge core_clk) disable iff (reset)
    data_ready |-> (exp_count > 0))
    else begin
      errors++;
      $display("data_ready was high at %0t while no entry was expected", $time);
    end

  a_head_match: assert property (@(posedge core_clk) disable iff (reset)
    (valid && exp_count > 0) |-> ({error, extended, data_out} == exp_head))
    else begin
      errors++;
      $display("MISMATCH at %0t: got err=%b ext=%b code=%h, expected %b %b %h", $time,
               error, extended, data_out, exp_head.error, exp_head.extended, exp_head.code);
    end

  function automatic void refresh_head();
    exp_count = exp_q.size();
    exp_head  = (exp_count > 0) ? exp_q[0] : '0;
  endfunction

  // counts every entry the DUT hands out, expected or not
  function automatic void drop_head();
    popped++;
    if (exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    refresh_head();
  endfunction

  // bad frames and completed releases are kept, as the frame format says
  function automatic void model_frame(input logic [7:0] code, input logic good);
    t_kbd_entry ent;
    logic       keep;
    keep         = !good;
    ent.error    = !good;
    ent.extended = 1'b0;
    ent.code     = code;
    if (!good) begin
      pfx_ext = 1'b0;
      pfx_brk = 1'b0;
    end else if (code == 8'hE0) begin
      pfx_ext = 1'b1;
      pfx_brk = 1'b0;
    end else if (code == 8'hF0) begin
      // F0 straight after E0 keeps the extended mark
      pfx_ext = pfx_ext && !pfx_brk;
      pfx_brk = 1'b1;
    end else begin
      keep         = pfx_brk;
      ent.extended = pfx_ext;
      pfx_ext      = 1'b0;
      pfx_brk      = 1'b0;
    end
    // a full FIFO drops the new entry
    if (keep && capture_on && exp_q.size() < `KBD_FIFO_DEPTH) begin
      exp_q.push_back(ent);
    end
    refresh_head();
  endfunction

  // lands a small delay after a core_clk rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge core_clk);
    #DRIVE_DLY;
  endtask

  task automatic send_bit(input logic b);
    data_in = b;
    wait_cycles(KBD_HALF);
    kbd_clk = 1'b1;
    wait_cycles(KBD_HALF);
    kbd_clk = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] code, input logic bad_parity);
    logic        parity;
    logic [10:0] bits;
    // odd count of ones over data and parity
    parity = ~^code ^ bad_parity;
    bits   = {1'b1, parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      if (i == 10) begin
        model_frame(code, !bad_parity);
      end
      send_bit(bits[i]);
    end
    data_in = 1'b1;
    wait_cycles(KBD_HALF);
  endtask

  // entries still queued after the limit are left for the final check
  task automatic drain_queue();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      wait_cycles(1);
      waited++;
    end
    // time for a stray entry to cross
    wait_cycles(8);
  endtask

  task automatic reset_dut();
    kbd_clk  = 1'b0;
    data_in  = 1'b1;
    reset    = 1'b1;
    read_en  = 1'b0;
    scanf_en = 1'b1;
    fork
      wait_cycles(RESET_CYCLES);
      repeat (RESET_PULSES) begin
        #35 kbd_clk = 1'b1;
        #35 kbd_clk = 1'b0;
      end
    join
    reset = 1'b0;
    // two idle edges clear the kbd_clk reset metaflop, bit count stays 0
    send_bit(1'b1);
    send_bit(1'b1);
    reads_off = 1'b0;
  endtask

  // read requests, head popped right after the edge that took it
  always begin
    @(negedge core_clk);
    took_head = valid;
    @(posedge core_clk);
    #DRIVE_DLY;
    if (took_head) begin
      drop_head();
    end
    read_en = reads_off ? 1'b0 : (($urandom % 2) == 1);
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge core_clk);
    $display("watchdog expired after %0d core cycles, run did not finish", WATCHDOG_CYCLES);
    $display("checks failed: %0d", errors);
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(RAND_SEED));
    reset_dut();
    // make alone, then one plain release
    send_frame(8'h1C, 1'b0);
    send_frame(8'hF0, 1'b0);
    send_frame(8'h1C, 1'b0);
    drain_queue();
    // extended release
    send_frame(8'hE0, 1'b0);
    send_frame(8'hF0, 1'b0);
    send_frame(8'h75, 1'b0);
    drain_queue();
    // bad frame after F0, following 1C is a make
    send_frame(8'hF0, 1'b0);
    send_frame(8'h4B, 1'b1);
    send_frame(8'h1C, 1'b0);
    drain_queue();
    // capture off
    scanf_en   = 1'b0;
    capture_on = 1'b0;
    send_frame(8'hF0, 1'b0);
    send_frame(8'h1C, 1'b0);
    send_frame(8'hE0, 1'b0);
    send_frame(8'hF0, 1'b0);
    send_frame(8'h75, 1'b0);
    drain_queue();
    scanf_en   = 1'b1;
    capture_on = 1'b1;
    // overflow with reads held off
    reads_off = 1'b1;
    wait_cycles(2);
    for (int i = 0; i < `KBD_FIFO_DEPTH + 2; i++) begin
      send_frame(8'hF0, 1'b0);
      send_frame(8'h15 + 8'(i), 1'b0);
    end
    reads_off = 1'b0;
    drain_queue();
    a_queue_empty: assert (exp_q.size() == 0)
      else begin
        errors++;
        $display("scoreboard still holds %0d entries at the end", exp_q.size());
      end
    a_read_count: assert (popped == 3 + `KBD_FIFO_DEPTH)
      else begin
        errors++;
        $display("read %0d entries, expected %0d", popped, 3 + `KBD_FIFO_DEPTH);
      end
    $display("checks failed: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hw
hw/kbd_pkg.sv
hw/ps2_frame_if.sv
hw/ps2_frame_shifter.sv
hw/ps2_frame_checker.sv
hw/scancode_tracker.sv
hw/kbd_entry_writer.sv
hw/kbd_gray_fifo.sv
hw/kbd_controller.sv
dv/kbd_controller_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the PS/2 receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module kbd_controller_tb -Mdir obj_dir

sim_out=$(./obj_dir/Vkbd_controller_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qF "All tests passed!"; then
  exit 0
else
  exit 1
fi
